// ==== Bender.yml ====
package:
  name: snd_board

sources:
  - files:
      - logic/snd_pkg.sv
      - logic/snd_addr_decode.sv
      - logic/snd_ctrl_regs.sv
      - logic/snd_mixer.sv
      - logic/snd_board_top.sv

  - target: simulation
    files:
      - tb/tb_clkgen.sv
      - tb/snd_board_tb.sv

# RTL top level: snd_board_top
# Testbench top level: snd_board_tb

// ==== build.f ====
logic/snd_pkg.sv
logic/snd_addr_decode.sv
logic/snd_ctrl_regs.sv
logic/snd_mixer.sv
logic/snd_board_top.sv
tb/tb_clkgen.sv
tb/snd_board_tb.sv

// ==== logic/snd_addr_decode.sv ====
// Sound CPU bus decoder, raises memory and port selects and forms the banked ROM address
`timescale 1ns/1ps

module snd_addr_decode import snd_pkg::*; (
    input  logic [15:0] addr,        // CPU address bus
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic        m1_n,        // Low during opcode fetch and int ack
    input  logic [7:0]  game_id,     // Board family lives in the top bits
    input  snd_bank_u   bank,        // From the control latch

    output logic        rom_cs,
    output logic        ram_cs,
    output logic        fm_cs,
    output logic        misc_cs,
    output logic        pcm_cs,
    output logic        mapper_cs,
    output logic [18:0] rom_addr
);

    logic bank_cs;      // Access inside 8000-DFFF
    logic io_cycle;     // Real port access, not an interrupt acknowledge

    // Socket select to ROM address bits 17:16
    function automatic logic [1:0] socket_msb(input logic [3:0] socket);
        logic [1:0] msb;
        msb = 2'd0;                 // Also covers an empty select
        if (socket[3]) begin
            msb = 2'd3;             // Top socket
        end else if (socket[2]) begin
            msb = 2'd2;
        end else if (socket[1]) begin
            msb = 2'd1;
        end
        return msb;
    endfunction

    // Memory selects
    always_comb begin
        ram_cs  = !mreq_n && (addr[15:11] == RAM_BASE_HI);
        bank_cs = !mreq_n && (addr[15:12] >= BANK_LO) && (addr[15:12] < BANK_HI);
        rom_cs  = (!mreq_n && !addr[15]) || bank_cs;  // Fixed half plus window
    end

    assign io_cycle = !iorq_n && m1_n;

    // Port selects and the mapper memory alias
    always_comb begin
        fm_cs     = 1'b0;
        misc_cs   = 1'b0;
        pcm_cs    = 1'b0;
        mapper_cs = 1'b0;
        if (io_cycle) begin
            case (addr[7:6])
                PORT_FM:     fm_cs     = 1'b1;
                PORT_MISC:   misc_cs   = 1'b1;
                PORT_PCM:    pcm_cs    = 1'b1;
                PORT_MAPPER: mapper_cs = 1'b1;
                default:     fm_cs     = 1'b0;
            endcase
        end else begin
            // Mailbox also answers at E800 in memory space
            mapper_cs = !mreq_n && (addr[15:11] == MAPPER_MEM_HI);
        end
    end

    // Banked ROM address
    always_comb begin
        rom_addr = {4'd0, addr[14:0]};             // Direct 32 KB view
        if (bank_cs) begin
            if (game_id[7:5] == 3'b001) begin
                // 5797 boards swap bank bits 3 and 4
                rom_addr[18:14] = {
                    bank.linear.bits[3],
                    bank.linear.spare[0],
                    bank.linear.bits[2:0]
                };
            end else if (game_id[7:3] == 5'b00011) begin
                // 5358 boards
                rom_addr[15:14] = bank.onehot.lo;
                rom_addr[17:16] = socket_msb(bank.onehot.socket);
            end else begin
                rom_addr[17:14] = bank.linear.bits;  // 5521 and 5704
            end
            rom_addr = rom_addr + BANK_OFFSET;       // Skip the fixed area
        end
    end

    // At most one chip select, memory and port cycles never overlap on the bus
    always_comb begin
        sel_onehot: assert final (
            $onehot0({rom_cs, ram_cs, fm_cs, misc_cs, pcm_cs, mapper_cs})
        ) else $error("More than one chip select active at %h", addr);
    end

endmodule

// ==== logic/snd_board_top.sv ====
// Sound board glue top level, wires the bus decoder, control registers and output mixer
`timescale 1ns/1ps

module snd_board_top import snd_pkg::*; #(
    parameter logic [7:0] FM_GAIN = 8'h10,
    parameter int         PCM_W   = 9
) (
    input  logic                    clk,
    input  logic                    rst,

    // CPU bus
    input  logic [15:0]             addr,
    input  logic                    mreq_n,
    input  logic                    iorq_n,
    input  logic                    m1_n,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic [7:0]              cpu_dout,
    output logic [7:0]              cpu_din,

    input  logic [7:0]              game_id,

    // Program ROM and work RAM
    output logic [18:0]             rom_addr,
    output logic                    rom_cs,
    input  logic [7:0]              rom_data,
    output logic                    ram_cs,
    input  logic [7:0]              ram_dout,

    // FM and PCM chips
    output logic                    fm_cs,
    input  logic [7:0]              fm_dout,
    output logic                    pcm_cs,
    input  logic                    pcm_busyn,
    output logic                    pcm_rst,
    output logic                    pcm_mdn,

    // Mapper mailbox
    output logic                    mapper_rd,
    output logic                    mapper_wr,
    output logic [7:0]              mapper_din,
    input  logic [7:0]              mapper_dout,

    // Audio
    input  logic signed [15:0]      fm_left,
    input  logic signed [15:0]      fm_right,
    input  logic signed [PCM_W-1:0] pcm_snd,
    input  logic [1:0]              fxlevel,
    input  logic                    enable_fm,
    input  logic                    enable_psg,
    output logic signed [15:0]      snd,
    output logic                    peak
);

    snd_bank_u bank;       // Latch back to the decoder
    logic      misc_cs;
    logic      mapper_cs;

    snd_addr_decode u_decode (
        .addr      (addr),
        .mreq_n    (mreq_n),
        .iorq_n    (iorq_n),
        .m1_n      (m1_n),
        .game_id   (game_id),
        .bank      (bank),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .fm_cs     (fm_cs),
        .misc_cs   (misc_cs),
        .pcm_cs    (pcm_cs),
        .mapper_cs (mapper_cs),
        .rom_addr  (rom_addr)
    );

    snd_ctrl_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .fm_cs       (fm_cs),
        .misc_cs     (misc_cs),
        .pcm_cs      (pcm_cs),
        .mapper_cs   (mapper_cs),
        .rom_cs      (rom_cs),
        .ram_cs      (ram_cs),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .cpu_dout    (cpu_dout),
        .rom_data    (rom_data),
        .ram_dout    (ram_dout),
        .fm_dout     (fm_dout),
        .mapper_dout (mapper_dout),
        .pcm_busyn   (pcm_busyn),
        .bank        (bank),
        .pcm_rst     (pcm_rst),
        .pcm_mdn     (pcm_mdn),
        .mapper_rd   (mapper_rd),
        .mapper_wr   (mapper_wr),
        .mapper_din  (mapper_din),
        .cpu_din     (cpu_din)
    );

    snd_mixer #(
        .FM_GAIN (FM_GAIN),
        .PCM_W   (PCM_W)
    ) u_mixer (
        .clk        (clk),
        .rst        (rst),
        .fm_left    (fm_left),
        .fm_right   (fm_right),
        .pcm_snd    (pcm_snd),
        .fxlevel    (fxlevel),
        .enable_fm  (enable_fm),
        .enable_psg (enable_psg),
        .snd        (snd),
        .peak       (peak)
    );

endmodule

// ==== logic/snd_ctrl_regs.sv ====
// Board control latch, mapper mailbox strobes and registered read-data path of the sound CPU
`timescale 1ns/1ps

module snd_ctrl_regs import snd_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // Selects from the decoder
    input  logic       fm_cs,
    input  logic       misc_cs,
    input  logic       pcm_cs,
    input  logic       mapper_cs,
    input  logic       rom_cs,
    input  logic       ram_cs,

    input  logic       rd_n,
    input  logic       wr_n,
    input  logic [7:0] cpu_dout,     // CPU write data

    // Read sources
    input  logic [7:0] rom_data,
    input  logic [7:0] ram_dout,
    input  logic [7:0] fm_dout,
    input  logic [7:0] mapper_dout,
    input  logic       pcm_busyn,    // Low while the PCM chip plays

    output snd_bank_u  bank,
    output logic       pcm_rst,
    output logic       pcm_mdn,      // 1 selects stand alone mode
    output logic       mapper_rd,
    output logic       mapper_wr,
    output logic [7:0] mapper_din,
    output logic [7:0] cpu_din
);

    logic misc_wr;

    assign misc_wr = misc_cs && !wr_n;

    // Mailbox strobes follow the CPU strobes directly
    assign mapper_rd  = mapper_cs && !rd_n;
    assign mapper_wr  = mapper_cs && !wr_n;
    assign mapper_din = cpu_dout;

    // Control latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank    <= '0;
            pcm_rst <= 1'b1;                         // PCM held in reset
            pcm_mdn <= 1'b1;
        end else if (misc_wr) begin
            bank    <= snd_bank_u'(cpu_dout[5:0]);
            pcm_rst <= ~cpu_dout[6];                 // Active low on the bus
            pcm_mdn <= ~cpu_dout[7];
        end
    end

    // Read data, fixed priority with open bus as FF
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 8'h00;
        end else if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (ram_cs) begin
            cpu_din <= ram_dout;
        end else if (fm_cs) begin
            cpu_din <= fm_dout;
        end else if (pcm_cs) begin
            cpu_din <= {pcm_busyn, 7'h7F};          // Only the busy flag is real
        end else if (mapper_cs) begin
            cpu_din <= mapper_dout;
        end else begin
            cpu_din <= 8'hFF;
        end
    end

    // CPU never reads and writes the mailbox in one cycle
    mapper_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst) !(mapper_rd && mapper_wr)
    ) else $error("Mapper read and write strobes overlap");

endmodule

// ==== logic/snd_mixer.sv ====
// Output mixer of FM left, FM right and filtered PCM with 4.4 gains, clamp and peak flag
`timescale 1ns/1ps

module snd_mixer import snd_pkg::*; #(
    parameter logic [7:0] FM_GAIN = 8'h10,   // 1.0 in 4.4
    parameter int         PCM_W   = 9
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic signed [15:0]      fm_left,
    input  logic signed [15:0]      fm_right,
    input  logic signed [PCM_W-1:0] pcm_snd,   // After the pole filter
    input  logic        [1:0]       fxlevel,   // PCM volume step
    input  logic                    enable_fm,
    input  logic                    enable_psg,

    output logic signed [15:0]      snd,
    output logic                    peak       // Set on a clipped sample
);

    // 16 bit sample times 9 bit signed gain, plus headroom for three terms
    localparam int PROD_W = 25;
    localparam int ACC_W  = PROD_W + 2;

    localparam logic signed [ACC_W-1:0] SND_MAX = 32767;
    localparam logic signed [ACC_W-1:0] SND_MIN = -32768;

    logic signed [8:0]        fm_gain;     // Unsigned gain with a zero sign bit
    logic signed [8:0]        pcm_gain;
    logic signed [15:0]       pcm_ext;
    logic signed [PROD_W-1:0] prod_left;
    logic signed [PROD_W-1:0] prod_right;
    logic signed [PROD_W-1:0] prod_pcm;
    logic signed [ACC_W-1:0]  sum;
    logic signed [ACC_W-1:0]  scaled;
    logic signed [15:0]       clamped;
    logic                     clip;

    // Gain selection
    always_comb begin
        fm_gain  = enable_fm  ? $signed({1'b0, FM_GAIN}) : 9'sd0;
        pcm_gain = enable_psg ? $signed({1'b0, PCM_GAIN_TABLE[fxlevel]}) : 9'sd0;
    end

    assign pcm_ext = pcm_snd;              // Sign extends to 16 bits

    // Weighted sum in 4.4, back to integer by the shift
    always_comb begin
        prod_left  = fm_left  * fm_gain;
        prod_right = fm_right * fm_gain;
        prod_pcm   = pcm_ext  * pcm_gain;
        sum        = prod_left + prod_right + prod_pcm;
        scaled     = sum >>> 4;
    end

    // Saturation to the 16 bit range
    always_comb begin
        clip    = 1'b0;
        clamped = scaled[15:0];
        if (scaled > SND_MAX) begin
            clamped = 16'sh7FFF;
            clip    = 1'b1;
        end else if (scaled < SND_MIN) begin
            clamped = 16'sh8000;
            clip    = 1'b1;
        end
    end

    // One cycle output register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd  <= 16'sd0;
            peak <= 1'b0;
        end else begin
            snd  <= clamped;
            peak <= clip;
        end
    end

    // A flagged sample sits on a rail, and muted channels can never clip
    peak_at_rail: assert property (
        @(posedge clk) disable iff (rst)
            peak |-> (snd == 16'sh7FFF || snd == 16'sh8000) && $past(enable_fm || enable_psg)
    ) else $error("Peak raised with snd = %0d", snd);

endmodule

// ==== logic/snd_pkg.sv ====
// Shared types and constants of the sound board glue, imported by the decoder, latch and mixer
package snd_pkg;

    // Bank byte written through the misc port, bits 5:0 of the CPU data
    typedef union packed {
        // 5797 and 5521/5704 boards
        struct packed {
            logic [1:0] spare;         // Bit 4 still feeds the 5797 swap
            logic [3:0] bits;          // Plain bank number
        } linear;
        // 5358 boards with one ROM socket select per bit
        struct packed {
            logic [3:0] socket;        // Socket select, highest set bit wins
            logic [1:0] lo;            // 16 KB page inside the socket
        } onehot;
    } snd_bank_u;

    // Memory map, compared against the top address bits

    // A15:A11 all ones
    localparam logic [4:0] RAM_BASE_HI = 5'b11111;    // F800-FFFF work RAM

    // A15:A12 range of the banked window
    localparam logic [3:0] BANK_LO = 4'h8;            // First nibble inside
    localparam logic [3:0] BANK_HI = 4'hE;            // First nibble outside

    localparam logic [4:0] MAPPER_MEM_HI = 5'b11101;  // E800 mapper alias

    // Banked pages sit above the fixed 32 KB
    localparam logic [18:0] BANK_OFFSET = 19'h10000;

    // I/O map on A7:A6
    localparam logic [1:0] PORT_FM     = 2'd0;        // FM synth
    localparam logic [1:0] PORT_MISC   = 2'd1;        // Control latch
    localparam logic [1:0] PORT_PCM    = 2'd2;        // ADPCM chip
    localparam logic [1:0] PORT_MAPPER = 2'd3;        // Mailbox

    // PCM gain per fxlevel, 4.4 fixed point
    // Index 0 is quarter gain, index 3 is double gain
    localparam logic [3:0][7:0] PCM_GAIN_TABLE = {
        8'h20,  // fxlevel 3
        8'h10,  // fxlevel 2
        8'h08,  // fxlevel 1
        8'h04   // fxlevel 0
    };

endpackage

// ==== tb/snd_board_tb.sv ====
// Self-checking testbench of the sound board glue, drives the CPU bus and audio inputs of the top
`timescale 1ns/1ps

module snd_board_tb;

    localparam logic [7:0] FM_GAIN = 8'h10;
    localparam int         PCM_W   = 9;
    localparam int         N_BANK  = 16;         // Latch writes per family
    localparam int         N_MIX   = 64;         // Random mixer samples

    // Fixed sections plus three cycles per bank step and one per sample
    localparam int TEST_CYCLES = 60 + 9 * N_BANK + N_MIX;
    localparam int TIMEOUT_NS  = TEST_CYCLES * 20 + 1000;

    localparam logic [1:0] FM_PORT     = 2'd0;
    localparam logic [1:0] MISC_PORT   = 2'd1;
    localparam logic [1:0] PCM_PORT    = 2'd2;
    localparam logic [1:0] MAPPER_PORT = 2'd3;

    logic                    clk;
    logic                    rst;
    logic [15:0]             addr;
    logic                    mreq_n;
    logic                    iorq_n;
    logic                    m1_n;
    logic                    rd_n;
    logic                    wr_n;
    logic [7:0]              cpu_dout;
    logic [7:0]              cpu_din;
    logic [7:0]              game_id;
    logic [18:0]             rom_addr;
    logic                    rom_cs;
    logic [7:0]              rom_data;
    logic                    ram_cs;
    logic [7:0]              ram_dout;
    logic                    fm_cs;
    logic [7:0]              fm_dout;
    logic                    pcm_cs;
    logic                    pcm_busyn;
    logic                    pcm_rst;
    logic                    pcm_mdn;
    logic                    mapper_rd;
    logic                    mapper_wr;
    logic [7:0]              mapper_din;
    logic [7:0]              mapper_dout;
    logic signed [15:0]      fm_left;
    logic signed [15:0]      fm_right;
    logic signed [PCM_W-1:0] pcm_snd;
    logic [1:0]              fxlevel;
    logic                    enable_fm;
    logic                    enable_psg;
    logic signed [15:0]      snd;
    logic                    peak;

    // Expected state, updated at the falling edge
    logic [5:0]  bank_model;
    logic        pcm_rst_model;
    logic        pcm_mdn_model;
    logic [7:0]  din_expect;      // Due at the next falling edge
    logic [16:0] mix_expect;      // {peak, snd}
    integer      seed;
    int          errors = 0;

    tb_clkgen #(.PERIOD_NS(20.0)) clkgen0 (.clk(clk), .rst(rst));

    snd_board_top #(.FM_GAIN(FM_GAIN), .PCM_W(PCM_W)) dut0 (.*);

    // Selects from the bus rules, {rom, ram, fm, misc, pcm, mapper}
    function automatic logic [5:0] ref_sel(input logic [15:0] a, input logic mreq,
                                           input logic iorq, input logic m1);
        logic       mem;
        logic       io;
        logic [5:0] s;
        mem  = !mreq;
        io   = !iorq && m1;    // m1 low is an interrupt acknowledge
        s    = 6'b0;
        s[5] = mem && (a < 16'hE000);                  // Fixed half and bank window
        s[4] = mem && (a >= 16'hF800);
        s[3] = io && (a[7:6] == FM_PORT);
        s[2] = io && (a[7:6] == MISC_PORT);
        s[1] = io && (a[7:6] == PCM_PORT);
        s[0] = io ? (a[7:6] == MAPPER_PORT) : (mem && a >= 16'hE800 && a < 16'hF000);
        return s;
    endfunction

    function automatic logic [18:0] ref_rom_addr(input logic [15:0] a, input logic [7:0] gid,
                                                 input logic [5:0] b, input logic mem);
        logic [4:0]  page;
        logic [1:0]  socket;
        logic [18:0] r;
        r = {4'd0, a[14:0]};
        if (mem && a >= 16'h8000 && a < 16'hE000) begin
            socket = 2'd0;
            for (int i = 0; i < 4; i++) begin
                if (b[2 + i]) begin
                    socket = i[1:0];                   // Highest set socket bit
                end
            end
            if (gid[7:4] == 4'b0010 || gid[7:4] == 4'b0011) begin
                page = {b[3], b[4], b[2], b[1], b[0]};
            end else if (gid[7:3] == 5'b00011) begin
                page = {1'b0, socket, b[1:0]};
            end else begin
                page = {1'b0, b[3:0]};
            end
            r = {page, a[13:0]} + 19'h10000;
        end
        return r;
    endfunction

    function automatic logic [7:0] ref_din(input logic [5:0] s, input logic [7:0] rom_d,
                                           input logic [7:0] ram_d, input logic [7:0] fm_d,
                                           input logic busyn, input logic [7:0] map_d);
        if (s[5]) return rom_d;
        if (s[4]) return ram_d;
        if (s[3]) return fm_d;
        if (s[1]) return {busyn, 7'h7F};
        if (s[0]) return map_d;
        return 8'hFF;                                  // Open bus
    endfunction

    function automatic logic [16:0] ref_mix(input logic signed [15:0] fl,
                                            input logic signed [15:0] fr,
                                            input logic signed [PCM_W-1:0] ps,
                                            input logic [1:0] fx, input logic en_fm,
                                            input logic en_pcm);
        int fm_g;
        int pcm_g;
        int total;
        fm_g  = en_fm ? int'(FM_GAIN) : 0;
        pcm_g = en_pcm ? (4 << fx) : 0;                // 0x04, 0x08, 0x10, 0x20
        total = (int'(fl) * fm_g + int'(fr) * fm_g + int'(ps) * pcm_g) >>> 4;
        if (total > 32767) begin
            return {1'b1, 16'h7FFF};
        end else if (total < -32768) begin
            return {1'b1, 16'h8000};
        end
        return {1'b0, total[15:0]};
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_addr(input logic [18:0] got, input logic [18:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %05h, expected %05h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mix(input logic signed [15:0] got_snd, input logic got_peak,
                             input logic [16:0] exp);
        if ({got_peak, got_snd} !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: mixer gave snd %0d peak %b, expected snd %0d peak %b",
                     $time, got_snd, got_peak, $signed(exp[15:0]), exp[16]);
            abort_run();
        end
    endtask

    // Compare at the falling edge, where every DUT output is settled
    always @(negedge clk) begin : compare
        logic [5:0] sel;
        sel = ref_sel(addr, mreq_n, iorq_n, m1_n);
        if (rst) begin
            bank_model    = 6'd0;
            pcm_rst_model = 1'b1;
            pcm_mdn_model = 1'b1;
            din_expect    = 8'h00;
            mix_expect    = 17'd0;
        end
        check_byte(cpu_din, din_expect, "cpu_din");
        check_mix(snd, peak, mix_expect);
        check_flag(pcm_rst, pcm_rst_model, "pcm_rst");
        check_flag(pcm_mdn, pcm_mdn_model, "pcm_mdn");
        check_flag(rom_cs, sel[5], "rom_cs");
        check_flag(ram_cs, sel[4], "ram_cs");
        check_flag(fm_cs, sel[3], "fm_cs");
        check_flag(pcm_cs, sel[1], "pcm_cs");
        check_flag(mapper_rd, sel[0] && !rd_n, "mapper_rd");
        check_flag(mapper_wr, sel[0] && !wr_n, "mapper_wr");
        check_byte(mapper_din, cpu_dout, "mapper_din");
        check_addr(rom_addr, ref_rom_addr(addr, game_id, bank_model, !mreq_n), "rom_addr");
        if (!rst) begin
            din_expect = ref_din(sel, rom_data, ram_dout, fm_dout, pcm_busyn, mapper_dout);
            mix_expect = ref_mix(fm_left, fm_right, pcm_snd, fxlevel, enable_fm, enable_psg);
            if (sel[2] && !wr_n) begin                 // Latch loads at the next edge
                bank_model    = cpu_dout[5:0];
                pcm_rst_model = ~cpu_dout[6];
                pcm_mdn_model = ~cpu_dout[7];
            end
        end
    end

    // Drive point just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic shuffle_sources();
        logic [31:0] r;
        r           = $random(seed);
        rom_data    = r[7:0];
        ram_dout    = r[15:8];
        fm_dout     = r[23:16];
        mapper_dout = r[31:24];
        r           = $random(seed);
        pcm_busyn   = r[0];
    endtask

    task automatic mem_cycle(input logic [15:0] a, input logic write, input logic [7:0] d);
        next_cycle();
        shuffle_sources();
        addr     = a;
        mreq_n   = 1'b0;
        iorq_n   = 1'b1;
        m1_n     = 1'b1;
        rd_n     = write;
        wr_n     = !write;
        cpu_dout = d;
    endtask

    // Upper address bits are junk on a port cycle
    task automatic io_cycle(input logic [1:0] port, input logic write, input logic [7:0] d,
                            input logic m1);
        logic [31:0] r;
        next_cycle();
        shuffle_sources();
        r        = $random(seed);
        addr     = {r[15:8], port, r[5:0]};
        mreq_n   = 1'b1;
        iorq_n   = 1'b0;
        m1_n     = m1;
        rd_n     = write;
        wr_n     = !write;
        cpu_dout = d;
    endtask

    task automatic idle_cycle();
        next_cycle();
        shuffle_sources();
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        m1_n   = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
    endtask

    task automatic mix_sample(input logic signed [15:0] fl, input logic signed [15:0] fr,
                              input logic signed [PCM_W-1:0] ps, input logic [1:0] fx,
                              input logic efm, input logic epsg);
        next_cycle();
        fm_left    = fl;
        fm_right   = fr;
        pcm_snd    = ps;
        fxlevel    = fx;
        enable_fm  = efm;
        enable_psg = epsg;
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Simulation timed out after %0d ns", TIMEOUT_NS);
        abort_run();
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] s;
        seed        = 25;
        addr        = 16'h0000;
        mreq_n      = 1'b1;
        iorq_n      = 1'b1;
        m1_n        = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        cpu_dout    = 8'h00;
        game_id     = 8'h00;
        rom_data    = 8'h00;
        ram_dout    = 8'h00;
        fm_dout     = 8'h00;
        mapper_dout = 8'h00;
        pcm_busyn   = 1'b1;
        fm_left     = 16'sd0;
        fm_right    = 16'sd0;
        pcm_snd     = '0;
        fxlevel     = 2'd0;
        enable_fm   = 1'b0;
        enable_psg  = 1'b0;
        wait (rst === 1'b0);

        // Fixed ROM, work RAM, the E000 hole and the mapper alias
        mem_cycle(16'h0000, 1'b0, 8'h00);
        mem_cycle(16'h7FFF, 1'b0, 8'h00);
        mem_cycle(16'h1234, 1'b0, 8'h00);
        mem_cycle(16'hF800, 1'b0, 8'h00);
        mem_cycle(16'hFFFF, 1'b1, 8'h5A);
        mem_cycle(16'hE123, 1'b0, 8'h00);
        mem_cycle(16'hE800, 1'b0, 8'h00);
        mem_cycle(16'hEFFF, 1'b1, 8'hC3);
        idle_cycle();

        // Banking per family, 5797 then 5358 then the rest
        for (int f = 0; f < 3; f++) begin
            for (int n = 0; n < N_BANK; n++) begin
                r = $random(seed);
                case (f)
                    0:       game_id = {3'b001, r[28:24]};
                    1:       game_id = {5'b00011, r[26:24]};
                    default: game_id = {2'b01, r[29:24]};    // 40-7F
                endcase
                io_cycle(MISC_PORT, 1'b1, r[7:0], 1'b1);
                s = $random(seed);
                mem_cycle(16'h8000 + (s[15:0] % 16'h6000), 1'b0, 8'h00);
                mem_cycle(16'h8000 + (s[31:16] % 16'h6000), 1'b0, 8'h00);
            end
        end

        // Every port read, then the same port as an interrupt acknowledge
        game_id = 8'h00;
        for (int p = 0; p < 4; p++) begin
            io_cycle(p[1:0], 1'b0, 8'h00, 1'b1);
            io_cycle(p[1:0], 1'b0, 8'h00, 1'b0);
        end
        io_cycle(PCM_PORT, 1'b0, 8'h00, 1'b1);
        pcm_busyn = 1'b1;                              // Chip idle
        io_cycle(PCM_PORT, 1'b0, 8'h00, 1'b1);
        pcm_busyn = 1'b0;                              // Chip playing
        for (int k = 0; k < 4; k++) begin
            io_cycle(MISC_PORT, 1'b1, {k[1:0], 6'h2A}, 1'b1);
        end
        io_cycle(MISC_PORT, 1'b1, 8'h00, 1'b0);        // No latch on an acknowledge
        io_cycle(MAPPER_PORT, 1'b1, 8'h77, 1'b1);
        idle_cycle();

        // Mixer, random then every level and enable pair, then full scale
        for (int n = 0; n < N_MIX; n++) begin
            r = $random(seed);
            s = $random(seed);
            mix_sample(r[15:0], r[31:16], s[8:0], s[10:9], s[11], s[12]);
        end
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            mix_sample(r[15:0], r[31:16], r[8:0], k[1:0], k[2], k[3]);
        end
        mix_sample(16'sh7FFF, 16'sh7FFF, 9'sh0FF, 2'd3, 1'b1, 1'b1);
        mix_sample(16'sh8000, 16'sh8000, 9'sh100, 2'd3, 1'b1, 1'b1);
        mix_sample(16'sh7FFF, 16'sh7FFF, 9'sh0FF, 2'd0, 1'b0, 1'b1);
        mix_sample(16'sh3FFF, 16'sh4000, 9'sh000, 2'd0, 1'b1, 1'b0);  // Exactly at the rail
        repeat (3) next_cycle();                       // Drain the last result

        if (errors == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// ==== tb/tb_clkgen.sv ====
// Clock and power-on reset source for the sound board testbench, instanced once by the top
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset spans the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;             // Released at the drive point
    end

endmodule
